// ==== common/pipe_trace_defines.svh ====
////////////////////////////////////////////////////////////
// Width macros for the instruction trace unit
// Tags, cycle stamps, program counters, hazard counts
////////////////////////////////////////////////////////////

`ifndef PIPE_TRACE_DEFINES_SVH
`define PIPE_TRACE_DEFINES_SVH

// Instruction tag, wraps after 256 fetches
`define PT_TAG_W 8

// Free running cycle counter and every stage stamp
`define PT_CYCLE_W 16

// Program counter of a fetched instruction
`define PT_PC_W 32

// Stall, flush and retirement counters
`define PT_CNT_W 16

`endif

// ==== common/pipe_trace_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the trace unit
// Tag, cycle, pc and count scalars, stage stamps, slot
////////////////////////////////////////////////////////////

`default_nettype none

package pipe_trace_pkg;

    `include "pipe_trace_defines.svh"

    ////////////////////////////////////////////////////////////
    // Scalars
    ////////////////////////////////////////////////////////////

    typedef logic [`PT_TAG_W-1:0]   tag_t;
    typedef logic [`PT_CYCLE_W-1:0] cycle_t;
    typedef logic [`PT_PC_W-1:0]    pc_t;
    typedef logic [`PT_CNT_W-1:0]   cnt_t;

    ////////////////////////////////////////////////////////////
    // Stage entry stamps and slot contents
    ////////////////////////////////////////////////////////////

    // First cycle spent in each stage, fetch in the top bits
    typedef struct packed {
        cycle_t fetch;
        cycle_t decode;
        cycle_t execute;
        cycle_t memory;
        cycle_t writeback;
    } stamp_t;

    // One pipeline slot
    typedef struct packed {
        logic   valid;    // Live instruction, otherwise a bubble
        tag_t   tag;
        pc_t    pc;
        stamp_t stamp;
    } slot_t;

endpackage

`default_nettype wire

// ==== common/trace_stage_if.sv ====
////////////////////////////////////////////////////////////
// Write-back slot link from the tag tracker to the reporter
// Slot contents plus the current cycle number
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface trace_stage_if;

    import pipe_trace_pkg::*;

    slot_t  wb_slot;    // Valid bit marks a live instruction this cycle
    cycle_t cycle;      // Cycle number seen by the tracker

    // Tracker side
    modport src (
        output wb_slot,
        output cycle
    );

    // Reporter side
    modport dst (
        input wb_slot,
        input cycle
    );

endinterface

`default_nettype wire

// ==== tracker/stage_tag_tracker.sv ====
////////////////////////////////////////////////////////////
// Pipeline slot model for the five stage CPU
// Tag assignment, stall and flush movement, entry stamps
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module stage_tag_tracker (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   fetch_valid,
    input  wire pipe_trace_pkg::pc_t    fetch_pc,
    input  wire logic                   stall,
    input  wire logic                   flush,
    input  wire pipe_trace_pkg::cycle_t cycle,
    trace_stage_if.src                  wb
);

    import pipe_trace_pkg::*;

    // Movement applied at the coming edge
    typedef enum logic [1:0] {
        MV_RUN,
        MV_STALL,
        MV_FLUSH
    } move_e;

    move_e  move;
    logic   accept;        // Fetch taken into decode
    cycle_t cycle_next;    // Cycle number after the edge
    tag_t   next_tag;

    slot_t  dec_q;
    slot_t  ex_q;
    slot_t  mem_q;
    slot_t  wb_q;          // Memory/write-back slot

    // Flush wins over stall
    always_comb begin
        if (flush) begin
            move = MV_FLUSH;
        end else if (stall) begin
            move = MV_STALL;
        end else begin
            move = MV_RUN;
        end
    end

    assign accept     = fetch_valid && (move == MV_RUN);
    assign cycle_next = cycle + 1'b1;

    ////////////////////////////////////////////////////////////
    // Tag counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= '0;
        end else if (accept) begin
            next_tag <= next_tag + 1'b1;   // Wraps
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot movement
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_q.valid <= 1'b0;
            ex_q.valid  <= 1'b0;
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else begin
            // Execute onward never holds
            wb_q               <= mem_q;
            mem_q              <= ex_q;
            mem_q.stamp.memory <= cycle_next;

            case (move)
                MV_RUN: begin
                    ex_q               <= dec_q;
                    ex_q.stamp.execute <= cycle_next;

                    dec_q.valid <= accept;
                    dec_q.tag   <= next_tag;
                    dec_q.pc    <= fetch_pc;
                    dec_q.stamp <= '{fetch: cycle, decode: cycle_next,
                                     execute: '0, memory: '0, writeback: '0};
                end
                MV_STALL: begin
                    ex_q.valid <= 1'b0;    // Bubble, decode holds
                end
                default: begin
                    // Decode dropped, presented fetch never tagged
                    ex_q.valid  <= 1'b0;
                    dec_q.valid <= 1'b0;
                end
            endcase
        end
    end

    // Write-back stamp is left for the reporter
    assign wb.wb_slot = wb_q;
    assign wb.cycle   = cycle;

endmodule

`default_nettype wire

// ==== logic/hazard_tally.sv ====
////////////////////////////////////////////////////////////
// Hazard counters beside the slot model
// Stall cycles, flush events, longest stall run
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module hazard_tally (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           stall,
    input  wire logic           flush,
    output pipe_trace_pkg::cnt_t total_stalls,
    output pipe_trace_pkg::cnt_t total_flushes,
    output pipe_trace_pkg::cnt_t longest_stall
);

    import pipe_trace_pkg::*;

    logic stall_cycle;    // Flush overrides a concurrent stall
    cnt_t run_len;        // Stall cycles in the current run
    cnt_t run_next;

    assign stall_cycle = stall && !flush;
    assign run_next    = run_len + 1'b1;

    ////////////////////////////////////////////////////////////
    // Totals, one edge behind the strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            total_stalls <= '0;
        end else if (stall_cycle) begin
            total_stalls <= total_stalls + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            total_flushes <= '0;
        end else if (flush) begin
            total_flushes <= total_flushes + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stall runs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            run_len       <= '0;
            longest_stall <= '0;
        end else if (stall_cycle) begin
            run_len <= run_next;
            if (run_next > longest_stall) begin
                longest_stall <= run_next;   // New record run
            end
        end else begin
            run_len <= '0;                   // Run broken
        end
    end

endmodule

`default_nettype wire

// ==== logic/retire_reporter.sv ====
////////////////////////////////////////////////////////////
// Retirement record builder
// Registered record, hazard deltas, retired count
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module retire_reporter (
    input  wire logic            clk,
    input  wire logic            rst,
    trace_stage_if.dst           wb,
    input  wire pipe_trace_pkg::cnt_t total_stalls,
    input  wire pipe_trace_pkg::cnt_t total_flushes,
    output logic                 retire_valid,
    output pipe_trace_pkg::tag_t   retire_tag,
    output pipe_trace_pkg::pc_t    retire_pc,
    output pipe_trace_pkg::stamp_t retire_stamp,
    output pipe_trace_pkg::cnt_t   retire_stalls,
    output pipe_trace_pkg::cnt_t   retire_flushes,
    output pipe_trace_pkg::cnt_t   retired_count
);

    import pipe_trace_pkg::*;

    logic capture;         // Live instruction in write-back
    cnt_t snap_stalls;     // Totals at the previous capture
    cnt_t snap_flushes;

    assign capture = wb.wb_slot.valid;

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid  <= 1'b0;
            retired_count <= '0;
            snap_stalls   <= '0;    // First record measures from reset
            snap_flushes  <= '0;
        end else begin
            retire_valid <= capture;    // One cycle pulse per slot
            if (capture) begin
                retired_count <= retired_count + 1'b1;
                snap_stalls   <= total_stalls;
                snap_flushes  <= total_flushes;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Record payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (capture) begin
            retire_tag   <= wb.wb_slot.tag;
            retire_pc    <= wb.wb_slot.pc;
            retire_stamp <= wb.wb_slot.stamp;

            // Write-back entry is the current cycle
            retire_stamp.writeback <= wb.cycle;

            // Growth since the last capture, wrap safe
            retire_stalls  <= total_stalls - snap_stalls;
            retire_flushes <= total_flushes - snap_flushes;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pipe_trace_top.sv ====
////////////////////////////////////////////////////////////
// Trace unit top level
// Cycle counter, slot model, hazard tally, retire reporter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pipe_trace_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   fetch_valid,
    input  wire pipe_trace_pkg::pc_t    fetch_pc,
    input  wire logic                   stall,
    input  wire logic                   flush,
    output logic                        retire_valid,
    output pipe_trace_pkg::tag_t        retire_tag,
    output pipe_trace_pkg::pc_t         retire_pc,
    output pipe_trace_pkg::stamp_t      retire_stamp,
    output pipe_trace_pkg::cnt_t        retire_stalls,
    output pipe_trace_pkg::cnt_t        retire_flushes,
    output pipe_trace_pkg::cnt_t        retired_count,
    output pipe_trace_pkg::cnt_t        total_stalls,
    output pipe_trace_pkg::cnt_t        total_flushes,
    output pipe_trace_pkg::cnt_t        longest_stall
);

    import pipe_trace_pkg::*;

    cycle_t cycle;    // Reads 0 in the first cycle out of reset

    trace_stage_if wb_if ();

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    stage_tag_tracker stage_tag_tracker_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .stall       (stall),
        .flush       (flush),
        .cycle       (cycle),
        .wb          (wb_if.src)
    );

    // Same strobes as the tracker, totals also leave the top
    hazard_tally hazard_tally_i (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .total_stalls  (total_stalls),
        .total_flushes (total_flushes),
        .longest_stall (longest_stall)
    );

    retire_reporter retire_reporter_i (
        .clk            (clk),
        .rst            (rst),
        .wb             (wb_if.dst),
        .total_stalls   (total_stalls),
        .total_flushes  (total_flushes),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_pc      (retire_pc),
        .retire_stamp   (retire_stamp),
        .retire_stalls  (retire_stalls),
        .retire_flushes (retire_flushes),
        .retired_count  (retired_count)
    );

endmodule

`default_nettype wire

// ==== dv/pipe_trace_tests.svh ====
////////////////////////////////////////////////////////////
// Directed tests for the trace unit
// Straight flow, stall, flush, both, random traffic
////////////////////////////////////////////////////////////

`ifndef PIPE_TRACE_TESTS_SVH
`define PIPE_TRACE_TESTS_SVH

// Six back to back fetches
task automatic test_straight_flow();
    int   first;
    int   i;
    tag_t base;
    first = seen.size();
    base  = m_tag;
    for (i = 0; i < 6; i++) begin
        step(1'b1, 32'h1000 + 4 * i, 1'b0, 1'b0);
    end
    drain();
    assert (seen.size() == first + 6) else
        log_error($sformatf("straight flow retired %0d, expected 6", seen.size() - first));
    for (i = first; i < seen.size(); i++) begin
        assert (seen[i].slot.tag == tag_t'((base + i - first) % TAG_MOD)) else
            log_error($sformatf("tag %0d retired out of order", seen[i].slot.tag));
        assert (cycle_t'(seen[i].pulse - seen[i].slot.stamp.fetch) == 5 &&
                cycle_t'(seen[i].slot.stamp.writeback - seen[i].slot.stamp.fetch) == 4) else
            log_error($sformatf("tag %0d latency is not five cycles", seen[i].slot.tag));
    end
endtask

// Three stall cycles with the first fetch in decode
task automatic test_stall();
    int   first;
    int   i;
    cnt_t stalls_before;
    first         = seen.size();
    stalls_before = total_stalls;
    step(1'b1, 32'h2000, 1'b0, 1'b0);
    for (i = 0; i < 3; i++) begin
        step(1'b1, 32'h2004, 1'b1, 1'b0);   // CPU keeps presenting
    end
    step(1'b1, 32'h2004, 1'b0, 1'b0);
    drain();
    assert (seen.size() == first + 2) else
        log_error("stall test did not retire two instructions");
    assert (cycle_t'(seen[first].slot.stamp.execute - seen[first].slot.stamp.fetch) == 5 &&
            cycle_t'(seen[first].slot.stamp.writeback - seen[first].slot.stamp.fetch) == 7 &&
            seen[first].stalls == 3 && seen[first + 1].stalls == 0) else
        log_error("stalled instruction has wrong stamps or stall count");
    assert (total_stalls == stalls_before + 3 && longest_stall == 3) else
        log_error($sformatf("stall totals %0d longest %0d", total_stalls, longest_stall));
endtask

// Flush with the second fetch in decode
task automatic test_flush();
    int   first;
    tag_t base;
    cnt_t flushes_before;
    first          = seen.size();
    base           = m_tag;
    flushes_before = total_flushes;
    step(1'b1, 32'h3000, 1'b0, 1'b0);
    step(1'b1, 32'h3004, 1'b0, 1'b0);   // Dropped from decode
    step(1'b1, 32'h3008, 1'b0, 1'b1);   // Never tagged
    step(1'b1, 32'h3100, 1'b0, 1'b0);
    drain();
    assert (seen.size() == first + 2 && seen[first].slot.tag == base &&
            seen[first + 1].slot.tag == tag_t'((base + 2) % TAG_MOD)) else
        log_error("flush left the wrong instructions retiring");
    assert (seen[first].flushes == 1 && seen[first + 1].flushes == 0 &&
            total_flushes == flushes_before + 1) else
        log_error("flush event not counted exactly once");
endtask

// Stall and flush in the same cycle
task automatic test_stall_and_flush();
    int   first;
    tag_t base;
    cnt_t stalls_before;
    cnt_t flushes_before;
    cnt_t longest_before;
    first          = seen.size();
    base           = m_tag;
    stalls_before  = total_stalls;
    flushes_before = total_flushes;
    longest_before = longest_stall;
    step(1'b1, 32'h4000, 1'b0, 1'b0);
    step(1'b1, 32'h4004, 1'b1, 1'b1);
    step(1'b1, 32'h4008, 1'b0, 1'b0);
    drain();
    assert (seen.size() == first + 1 && seen[first].slot.tag == tag_t'((base + 1) % TAG_MOD) &&
            seen[first].flushes == 1 && seen[first].stalls == 0) else
        log_error("flush did not win over the concurrent stall");
    assert (total_stalls == stalls_before && total_flushes == flushes_before + 1 &&
            longest_stall == longest_before) else
        log_error("concurrent stall changed the stall totals");
endtask

task automatic test_random_traffic();
    int   i;
    logic fv;
    logic st;
    logic fl;
    pc_t  pc;
    for (i = 0; i < RUN_LEN; i++) begin
        fv = ({$random(seed)} % 4) != 0;
        st = ({$random(seed)} % 8) == 0;
        fl = ({$random(seed)} % 16) == 0;
        pc = $random(seed);
        step(fv, pc, st, fl);
    end
    drain();
    assert (retired_count == m_retired && retired_count == cnt_t'(seen.size())) else
        log_error($sformatf("retired %0d, model %0d", retired_count, m_retired));
    assert (total_stalls == m_stalls && total_flushes == m_flushes &&
            longest_stall == m_longest) else
        log_error("hazard totals differ from the model after random traffic");
endtask

`endif

// ==== dv/pipe_trace_tb.sv ====
////////////////////////////////////////////////////////////
// Trace unit testbench top
// Clock, reset, DUT, reference model, timeout, report
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "pipe_trace_defines.svh"

module pipe_trace_tb;

    import pipe_trace_pkg::*;

    localparam int TAG_MOD     = 1 << `PT_TAG_W;
    localparam int RUN_LEN     = 200;    // Random traffic cycles
    // Cycles of the five tests with their drain
    localparam int TEST_CYCLES = 12 + 12 + 10 + 9 + RUN_LEN + 8;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic   clk;
    logic   rst;
    logic   fetch_valid;
    pc_t    fetch_pc;
    logic   stall;
    logic   flush;
    logic   retire_valid;
    tag_t   retire_tag;
    pc_t    retire_pc;
    stamp_t retire_stamp;
    cnt_t   retire_stalls;
    cnt_t   retire_flushes;
    cnt_t   retired_count;
    cnt_t   total_stalls;
    cnt_t   total_flushes;
    cnt_t   longest_stall;

    // Model instruction and its stage from 1 (decode) to 4 (write-back)
    typedef struct packed {
        logic [2:0] stage;
        slot_t      slot;
    } flight_t;

    // One retirement record plus the cycle of its pulse
    typedef struct packed {
        slot_t  slot;
        cnt_t   stalls;
        cnt_t   flushes;
        cycle_t pulse;
    } seen_t;

    flight_t flight[$];           // In-flight instructions of the model
    seen_t   seen[$];             // Records observed on the outputs
    seen_t   expected;
    logic    expected_valid = 1'b0;
    cycle_t  m_cycle        = '0;
    tag_t    m_tag          = '0;
    cnt_t    m_stalls       = '0;
    cnt_t    m_flushes      = '0;
    cnt_t    m_run          = '0;
    cnt_t    m_longest      = '0;
    cnt_t    m_retired      = '0;
    cnt_t    snap_stalls    = '0; // Model totals at the last retirement
    cnt_t    snap_flushes   = '0;
    integer  seed           = 7982;
    int      errors         = 0;
    int      cycles         = 0;

    pipe_trace_top pipe_trace_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, tests did not finish", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic log_error(input string msg);
        errors = errors + 1;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model of the CPU movement
    ////////////////////////////////////////////////////////////

    task automatic model_cycle(input logic fv, input pc_t pc, input logic st, input logic fl);
        flight_t next_q[$];
        flight_t f;
        cycle_t  nxt;
        nxt            = m_cycle + 1'b1;
        expected_valid = 1'b0;
        foreach (flight[i]) begin
            f = flight[i];
            if (f.stage == 3'd4) begin
                // Leaves write-back and shows as a record next cycle
                expected_valid                = 1'b1;
                expected.slot                 = f.slot;
                expected.slot.stamp.writeback = m_cycle;
                expected.stalls               = m_stalls - snap_stalls;
                expected.flushes              = m_flushes - snap_flushes;
                expected.pulse                = nxt;
                snap_stalls                   = m_stalls;
                snap_flushes                  = m_flushes;
                m_retired                     = m_retired + 1'b1;
            end else if (f.stage != 3'd1 || !(st || fl)) begin
                f.stage = f.stage + 1'b1;
                if (f.stage == 3'd2) begin
                    f.slot.stamp.execute = nxt;
                end else if (f.stage == 3'd3) begin
                    f.slot.stamp.memory = nxt;
                end
                next_q.push_back(f);
            end else if (!fl) begin
                next_q.push_back(f);    // Held in decode
            end
        end
        if (fv && !st && !fl) begin
            f.stage             = 3'd1;
            f.slot              = '0;
            f.slot.valid        = 1'b1;
            f.slot.tag          = m_tag;
            f.slot.pc           = pc;
            f.slot.stamp.fetch  = m_cycle;
            f.slot.stamp.decode = nxt;
            next_q.push_back(f);
            m_tag = m_tag + 1'b1;
        end
        flight = next_q;
        if (fl) begin
            m_flushes = m_flushes + 1'b1;
        end else if (st) begin
            m_stalls = m_stalls + 1'b1;
        end
        if (st && !fl) begin
            m_run = m_run + 1'b1;
            if (m_run > m_longest) begin
                m_longest = m_run;
            end
        end else begin
            m_run = '0;
        end
        m_cycle = nxt;
    endtask

    task automatic check_outputs();
        seen_t obs;
        obs.slot.valid = 1'b1;
        obs.slot.tag   = retire_tag;
        obs.slot.pc    = retire_pc;
        obs.slot.stamp = retire_stamp;
        obs.stalls     = retire_stalls;
        obs.flushes    = retire_flushes;
        obs.pulse      = m_cycle;
        assert (retire_valid === expected_valid) else
            log_error($sformatf("retire_valid %b, expected %b", retire_valid, expected_valid));
        if (retire_valid === 1'b1) begin
            seen.push_back(obs);
            assert (!expected_valid || obs === expected) else
                log_error($sformatf("tag %0d stamp %h hazards %0d %0d, expected %0d %h %0d %0d",
                    obs.slot.tag, obs.slot.stamp, obs.stalls, obs.flushes, expected.slot.tag,
                    expected.slot.stamp, expected.stalls, expected.flushes));
        end
        assert (retired_count === m_retired && total_stalls === m_stalls &&
                total_flushes === m_flushes && longest_stall === m_longest) else
            log_error($sformatf("counts %0d %0d %0d %0d, model %0d %0d %0d %0d", retired_count,
                total_stalls, total_flushes, longest_stall, m_retired, m_stalls, m_flushes,
                m_longest));
    endtask

    // One cycle of strobes and the checks after its edge
    task automatic step(input logic fv, input pc_t pc, input logic st, input logic fl);
        fetch_valid = fv;
        fetch_pc    = pc;
        stall       = st;
        flush       = fl;
        model_cycle(fv, pc, st, fl);
        @(posedge clk);
        #1;
        check_outputs();
    endtask

    task automatic drain();
        while (flight.size() != 0 || expected_valid) begin
            step(1'b0, '0, 1'b0, 1'b0);
        end
    endtask

    `include "pipe_trace_tests.svh"

    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_outputs();    // Idle state out of reset
        test_straight_flow();
        test_stall_and_flush();    // Longest run still zero here
        test_stall();
        test_flush();
        test_random_traffic();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipe_trace.f ====
+incdir+common
+incdir+dv
common/pipe_trace_pkg.sv
common/trace_stage_if.sv
tracker/stage_tag_tracker.sv
logic/hazard_tally.sv
logic/retire_reporter.sv
logic/pipe_trace_top.sv
dv/pipe_trace_tb.sv
